/* logic/alu.sv */
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  wire  [riscv_isa_pkg::xlen-1:0]    a,
    input  wire  [riscv_isa_pkg::xlen-1:0]    b,
    input  wire  datapath_pkg::alu_op_e       alu_ctrl,
    output logic [riscv_isa_pkg::xlen-1:0]    result,
    output datapath_pkg::alu_flags_t          flags
);
    logic                           sub;
    logic [riscv_isa_pkg::xlen-1:0] b_eff;
    logic [riscv_isa_pkg::xlen:0]   sum;
    logic                           ovf;
    logic                           lt;

    // One adder serves ADD, SUB and SLT.
    // Subtraction is a + ~b + 1.
    assign sub = (alu_ctrl == datapath_pkg::alu_sub) || (alu_ctrl == datapath_pkg::alu_slt);
    assign b_eff = sub ? ~b : b;
    assign sum = {1'b0, a} + {1'b0, b_eff} + {{riscv_isa_pkg::xlen{1'b0}}, sub};

    // Signed overflow when both inputs agree in sign and the sum does not.
    assign ovf = (a[riscv_isa_pkg::xlen-1] == b_eff[riscv_isa_pkg::xlen-1])
              && (sum[riscv_isa_pkg::xlen-1] != a[riscv_isa_pkg::xlen-1]);

    // Signed less than, corrected for overflow.
    assign lt = sum[riscv_isa_pkg::xlen-1] ^ ovf;

    always_comb begin
        case (alu_ctrl)
            datapath_pkg::alu_add:    result = sum[riscv_isa_pkg::xlen-1:0];
            datapath_pkg::alu_sub:    result = sum[riscv_isa_pkg::xlen-1:0];
            datapath_pkg::alu_and:    result = a & b;
            datapath_pkg::alu_or:     result = a | b;
            datapath_pkg::alu_xor:    result = a ^ b;
            datapath_pkg::alu_slt:    result = {{(riscv_isa_pkg::xlen-1){1'b0}}, lt};
            // Shift amount is the low five bits of b.
            datapath_pkg::alu_sll:    result = a << b[4:0];
            datapath_pkg::alu_srl:    result = a >> b[4:0];
            datapath_pkg::alu_sra:    result = $signed(a) >>> b[4:0];
            datapath_pkg::alu_pass_b: result = b;
            default:                  result = '0;
        endcase
    end

    // N and Z follow the result.
    // C and V come from the adder.
    assign flags.n = result[riscv_isa_pkg::xlen-1];
    assign flags.z = (result == '0);
    assign flags.c = sum[riscv_isa_pkg::xlen];
    assign flags.v = ovf;
endmodule

`default_nettype wire

/* logic/control_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module control_unit (
    input  wire                               rst_n,
    input  wire  [riscv_isa_pkg::xlen-1:0]    instr,
    input  wire  datapath_pkg::alu_flags_t    alu_flags,
    output datapath_pkg::ctrl_t               ctrl
);
    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic                  alt;
    logic                  branch_taken;
    datapath_pkg::alu_op_e alu_fn;
    datapath_pkg::ctrl_t   dec;

    // Instruction fields.
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign alt = (instr[31:25] == riscv_isa_pkg::funct7_alt);

    // ALU operation from funct3.
    // SUB only exists in register form, ADDI carries immediate bits in funct7.
    always_comb begin
        case (funct3)
            riscv_isa_pkg::f3_add_sub: begin
                alu_fn = (alt && opcode == riscv_isa_pkg::op_reg) ?
                         datapath_pkg::alu_sub : datapath_pkg::alu_add;
            end
            riscv_isa_pkg::f3_sll:     alu_fn = datapath_pkg::alu_sll;
            riscv_isa_pkg::f3_slt:     alu_fn = datapath_pkg::alu_slt;
            riscv_isa_pkg::f3_xor:     alu_fn = datapath_pkg::alu_xor;
            riscv_isa_pkg::f3_srl_sra: alu_fn = alt ? datapath_pkg::alu_sra : datapath_pkg::alu_srl;
            riscv_isa_pkg::f3_or:      alu_fn = datapath_pkg::alu_or;
            riscv_isa_pkg::f3_and:     alu_fn = datapath_pkg::alu_and;
            default:                   alu_fn = datapath_pkg::alu_add;
        endcase
    end

    // Branch condition from the flags of rs1 - rs2.
    always_comb begin
        case (funct3)
            riscv_isa_pkg::f3_beq: branch_taken = alu_flags.z;
            riscv_isa_pkg::f3_bne: branch_taken = !alu_flags.z;
            riscv_isa_pkg::f3_blt: branch_taken = alu_flags.n != alu_flags.v;
            riscv_isa_pkg::f3_bge: branch_taken = alu_flags.n == alu_flags.v;
            default:               branch_taken = 1'b0;
        endcase
    end

    // Main decoder.
    always_comb begin
        // Defaults: no writes, fall through to pc + 4.
        dec.reg_we     = 1'b0;
        dec.mem_we     = 1'b0;
        dec.imm_src    = datapath_pkg::imm_i;
        dec.alu_ctrl   = datapath_pkg::alu_add;
        dec.alu_src_a  = datapath_pkg::alu_src_reg_1;
        dec.alu_src_b  = datapath_pkg::alu_src_ext_imm;
        dec.result_src = datapath_pkg::res_src_alu_out;
        dec.pc_src     = datapath_pkg::pc_src_plus_4;
        case (opcode)
            riscv_isa_pkg::op_reg: begin
                dec.reg_we    = 1'b1;
                dec.alu_ctrl  = alu_fn;
                dec.alu_src_b = datapath_pkg::alu_src_reg_2;
            end
            riscv_isa_pkg::op_imm: begin
                dec.reg_we   = 1'b1;
                dec.alu_ctrl = alu_fn;
            end
            // Address is rs1 + imm, word size only.
            riscv_isa_pkg::op_load: begin
                dec.reg_we     = (funct3 == riscv_isa_pkg::f3_word);
                dec.result_src = datapath_pkg::res_src_mem;
            end
            riscv_isa_pkg::op_store: begin
                dec.mem_we  = (funct3 == riscv_isa_pkg::f3_word);
                dec.imm_src = datapath_pkg::imm_s;
            end
            // Compare via subtraction, target is pc + offset.
            riscv_isa_pkg::op_branch: begin
                dec.imm_src   = datapath_pkg::imm_b;
                dec.alu_ctrl  = datapath_pkg::alu_sub;
                dec.alu_src_b = datapath_pkg::alu_src_reg_2;
                dec.pc_src    = branch_taken ? datapath_pkg::pc_src_plus_off :
                                               datapath_pkg::pc_src_plus_4;
            end
            // Jumps link pc + 4 into rd.
            riscv_isa_pkg::op_jal: begin
                dec.reg_we     = 1'b1;
                dec.imm_src    = datapath_pkg::imm_j;
                dec.result_src = datapath_pkg::res_src_pc_plus_4;
                dec.pc_src     = datapath_pkg::pc_src_plus_off;
            end
            riscv_isa_pkg::op_jalr: begin
                dec.reg_we     = 1'b1;
                dec.result_src = datapath_pkg::res_src_pc_plus_4;
                dec.pc_src     = datapath_pkg::pc_src_reg_plus_off;
            end
            riscv_isa_pkg::op_lui: begin
                dec.reg_we     = 1'b1;
                dec.imm_src    = datapath_pkg::imm_u;
                dec.result_src = datapath_pkg::res_src_ext_imm;
            end
            // pc + upper immediate through the ALU.
            riscv_isa_pkg::op_auipc: begin
                dec.reg_we    = 1'b1;
                dec.imm_src   = datapath_pkg::imm_u;
                dec.alu_src_a = datapath_pkg::alu_src_pc;
            end
            default: begin
                dec.reg_we = 1'b0;
            end
        endcase
    end

    // No register or memory writes while in reset.
    always_comb begin
        ctrl = dec;
        ctrl.reg_we = dec.reg_we & rst_n;
        ctrl.mem_we = dec.mem_we & rst_n;
    end
endmodule

`default_nettype wire

/* logic/cpu_top.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_top (
    input  wire                               clk,
    input  wire                               rst_n,
    output wire  [riscv_isa_pkg::xlen-1:0]    imem_addr,
    input  wire  [riscv_isa_pkg::xlen-1:0]    instr,
    output wire  [riscv_isa_pkg::xlen-1:0]    dmem_addr,
    output wire  [riscv_isa_pkg::xlen-1:0]    dmem_wdata,
    output wire                               dmem_we,
    input  wire  [riscv_isa_pkg::xlen-1:0]    dmem_rdata
);
    // Control word and flags between the two halves.
    datapath_pkg::ctrl_t      ctrl;
    datapath_pkg::alu_flags_t alu_flags;

    control_unit cu (
        .rst_n     (rst_n),
        .instr     (instr),
        .alu_flags (alu_flags),
        .ctrl      (ctrl)
    );

    // pc fetches, ALU result addresses data memory.
    datapath dp (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr      (instr),
        .read_data  (dmem_rdata),
        .ctrl       (ctrl),
        .pc         (imem_addr),
        .alu_out    (dmem_addr),
        .write_data (dmem_wdata),
        .alu_flags  (alu_flags)
    );

    assign dmem_we = ctrl.mem_we;
endmodule

`default_nettype wire

/* logic/datapath.sv */
`timescale 1ns/100ps
`default_nettype none

module datapath (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire  [riscv_isa_pkg::xlen-1:0]    instr,
    input  wire  [riscv_isa_pkg::xlen-1:0]    read_data,
    input  wire  datapath_pkg::ctrl_t         ctrl,
    output logic [riscv_isa_pkg::xlen-1:0]    pc,
    output logic [riscv_isa_pkg::xlen-1:0]    alu_out,
    output logic [riscv_isa_pkg::xlen-1:0]    write_data,
    output datapath_pkg::alu_flags_t          alu_flags
);
    logic [riscv_isa_pkg::xlen-1:0] pc_plus_4;
    logic [riscv_isa_pkg::xlen-1:0] pc_plus_off;
    logic [riscv_isa_pkg::xlen-1:0] reg_sum;
    logic [riscv_isa_pkg::xlen-1:0] pc_reg_plus_off;
    logic [riscv_isa_pkg::xlen-1:0] pc_next;
    logic [riscv_isa_pkg::xlen-1:0] reg_rd1;
    logic [riscv_isa_pkg::xlen-1:0] reg_rd2;
    logic [riscv_isa_pkg::xlen-1:0] reg_wr_data;
    logic [riscv_isa_pkg::xlen-1:0] ext_imm;
    logic [riscv_isa_pkg::xlen-1:0] alu_op_a;
    logic [riscv_isa_pkg::xlen-1:0] alu_op_b;

    // Next PC candidates.
    assign pc_plus_4 = pc + 32'd4;
    assign pc_plus_off = pc + ext_imm;
    assign reg_sum = reg_rd1 + ext_imm;

    // JALR target has bit 0 cleared.
    assign pc_reg_plus_off = {reg_sum[riscv_isa_pkg::xlen-1:1], 1'b0};

    always_comb begin
        case (ctrl.pc_src)
            datapath_pkg::pc_src_plus_off:     pc_next = pc_plus_off;
            datapath_pkg::pc_src_reg_plus_off: pc_next = pc_reg_plus_off;
            default:                           pc_next = pc_plus_4;
        endcase
    end

    // PC register, cleared to the reset vector 0.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    // Write back source.
    always_comb begin
        case (ctrl.result_src)
            datapath_pkg::res_src_alu_out:   reg_wr_data = alu_out;
            datapath_pkg::res_src_pc_plus_4: reg_wr_data = pc_plus_4;
            datapath_pkg::res_src_ext_imm:   reg_wr_data = ext_imm;
            datapath_pkg::res_src_mem:       reg_wr_data = read_data;
            default:                         reg_wr_data = alu_out;
        endcase
    end

    // rs1, rs2 and rd sit at fixed positions in every format.
    regfile rf (
        .clk (clk),
        .a1  (instr[19:15]),
        .a2  (instr[24:20]),
        .a3  (instr[11:7]),
        .wd3 (reg_wr_data),
        .we3 (ctrl.reg_we),
        .rd1 (reg_rd1),
        .rd2 (reg_rd2)
    );

    // Store data is always rs2.
    assign write_data = reg_rd2;

    extend ext (
        .instr   (instr),
        .imm_src (ctrl.imm_src),
        .ext_imm (ext_imm)
    );

    // Operand selection, both sides use the same source set.
    always_comb begin
        case (ctrl.alu_src_a)
            datapath_pkg::alu_src_reg_1:   alu_op_a = reg_rd1;
            datapath_pkg::alu_src_reg_2:   alu_op_a = reg_rd2;
            datapath_pkg::alu_src_ext_imm: alu_op_a = ext_imm;
            default:                       alu_op_a = pc;
        endcase
    end

    always_comb begin
        case (ctrl.alu_src_b)
            datapath_pkg::alu_src_reg_1:   alu_op_b = reg_rd1;
            datapath_pkg::alu_src_reg_2:   alu_op_b = reg_rd2;
            datapath_pkg::alu_src_ext_imm: alu_op_b = ext_imm;
            default:                       alu_op_b = pc;
        endcase
    end

    alu alu0 (
        .a        (alu_op_a),
        .b        (alu_op_b),
        .alu_ctrl (ctrl.alu_ctrl),
        .result   (alu_out),
        .flags    (alu_flags)
    );
endmodule

`default_nettype wire

/* logic/datapath_pkg.sv */
`default_nettype none

package datapath_pkg;

    // Immediate format the extender builds.
    typedef enum logic [2:0] {
        imm_i,
        imm_s,
        imm_b,
        imm_j,
        imm_u
    } imm_src_e;

    // Operation performed by the ALU.
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_pass_b
    } alu_op_e;

    // Source of either ALU operand.
    typedef enum logic [1:0] {
        alu_src_reg_1,
        alu_src_reg_2,
        alu_src_ext_imm,
        alu_src_pc
    } alu_src_e;

    // Source of the value written back to the register file.
    typedef enum logic [1:0] {
        res_src_alu_out,
        res_src_pc_plus_4,
        res_src_ext_imm,
        res_src_mem
    } res_src_e;

    // Next PC selection.
    typedef enum logic [1:0] {
        pc_src_plus_4,
        pc_src_plus_off,
        pc_src_reg_plus_off
    } pc_src_e;

    // ALU status flags, used for branch decisions.
    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } alu_flags_t;

    // Control word from the control unit to the datapath, 17 bits.
    typedef struct packed {
        logic     reg_we;
        logic     mem_we;
        imm_src_e imm_src;
        alu_op_e  alu_ctrl;
        alu_src_e alu_src_a;
        alu_src_e alu_src_b;
        res_src_e result_src;
        pc_src_e  pc_src;
    } ctrl_t;

endpackage

`default_nettype wire

/* logic/extend.sv */
`timescale 1ns/100ps
`default_nettype none

module extend (
    input  wire  [riscv_isa_pkg::xlen-1:0]    instr,
    input  wire  datapath_pkg::imm_src_e      imm_src,
    output logic [riscv_isa_pkg::xlen-1:0]    ext_imm
);
    // The sign bit of every format is instr[31].
    always_comb begin
        case (imm_src)
            // I-type, instr[31:20].
            datapath_pkg::imm_i: begin
                ext_imm = {{20{instr[31]}}, instr[31:20]};
            end
            // S-type, offset split around rd.
            datapath_pkg::imm_s: begin
                ext_imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            // B-type, halfword offset so bit 0 is always clear.
            datapath_pkg::imm_b: begin
                ext_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            // J-type, 21 bit halfword offset.
            datapath_pkg::imm_j: begin
                ext_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            // U-type, upper 20 bits with the low 12 zero filled.
            datapath_pkg::imm_u: begin
                ext_imm = {instr[31:12], 12'b0};
            end
            default: begin
                ext_imm = '0;
            end
        endcase
    end
endmodule

`default_nettype wire

/* logic/regfile.sv */
`timescale 1ns/100ps
`default_nettype none

module regfile (
    input  wire                               clk,
    input  wire  [4:0]                        a1,
    input  wire  [4:0]                        a2,
    input  wire  [4:0]                        a3,
    input  wire  [riscv_isa_pkg::xlen-1:0]    wd3,
    input  wire                               we3,
    output logic [riscv_isa_pkg::xlen-1:0]    rd1,
    output logic [riscv_isa_pkg::xlen-1:0]    rd2
);
    // Architectural registers.
    // Entry 0 is never written, its reads are forced to zero below.
    logic [riscv_isa_pkg::xlen-1:0] regs [riscv_isa_pkg::reg_count];

    // Write port, taken on the rising edge.
    always_ff @(posedge clk) begin
        if (we3 && (a3 != 5'd0)) begin
            regs[a3] <= wd3;
        end
    end

    // Combinational read ports.
    // x0 always reads as zero.
    assign rd1 = (a1 == 5'd0) ? '0 : regs[a1];
    assign rd2 = (a2 == 5'd0) ? '0 : regs[a2];
endmodule

`default_nettype wire

/* logic/riscv_isa_pkg.sv */
`default_nettype none

package riscv_isa_pkg;

    // Machine word and register file size.
    localparam int xlen = 32;
    localparam int reg_count = 32;

    // Major opcodes, found in instr[6:0].
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;

    // ALU funct3 codes, shared by the register and immediate forms.
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // Branch funct3 codes.
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;
    localparam logic [2:0] f3_blt = 3'b100;
    localparam logic [2:0] f3_bge = 3'b101;

    // Only full word loads and stores are supported.
    localparam logic [2:0] f3_word = 3'b010;

    // funct7 value selecting SUB over ADD and SRA over SRL.
    localparam logic [6:0] funct7_alt = 7'b0100000;

endpackage

`default_nettype wire

/* project.f */
+incdir+verif
logic/riscv_isa_pkg.sv
logic/datapath_pkg.sv
logic/regfile.sv
logic/extend.sv
logic/alu.sv
logic/datapath.sv
logic/control_unit.sv
logic/cpu_top.sv
verif/tb_cpu.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the CPU testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_cpu \
    -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_cpu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION FAILED" sim.log; then
    exit 1
fi
exit 0

/* verif/tb_program.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// R-type word, opcode fixed to the register ALU group.
function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, riscv_isa_pkg::op_reg};
endfunction

function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

// Word store only.
function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, riscv_isa_pkg::f3_word, imm[4:0], riscv_isa_pkg::op_store};
endfunction

// Offset bit 0 is implied zero.
function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], riscv_isa_pkg::op_branch};
endfunction

function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                       input logic [6:0] op);
    return {imm, rd, op};
endfunction

function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, riscv_isa_pkg::op_jal};
endfunction

// Branch outcome per RV32I, rs1 against rs2.
function automatic logic branch_rule(input logic [2:0] f3, input logic [31:0] x,
                                     input logic [31:0] y);
    case (f3)
        3'b000:  return x == y;
        3'b001:  return x != y;
        3'b100:  return $signed(x) < $signed(y);
        default: return $signed(x) >= $signed(y);
    endcase
endfunction

// Places the next word at the write pointer.
task automatic emit(input logic [31:0] word);
    rom[wp] = word;
    wp++;
endtask

task automatic expect_store(input int t, input logic [11:0] off, input logic [31:0] value);
    exp_addr.push_back({20'h0, off});
    exp_data.push_back(value);
    exp_test.push_back(t);
    exp_cnt[t]++;
endtask

// SW rs, off(x0) with its expected value.
task automatic store(input int t, input logic [4:0] rs, input logic [11:0] off,
                     input logic [31:0] value);
    emit(s_type(off, rs, 5'd0));
    expect_store(t, off, value);
endtask

// One ALU instruction into x4, then x4 stored.
task automatic alu_case(input logic [31:0] word, input logic [11:0] off,
                        input logic [31:0] value);
    emit(word);
    store(1, 5'd4, off, value);
endtask

`endif

/* verif/tb_cpu.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_cpu;
    logic        clk = 1'b0;
    logic        rst_n;
    logic [31:0] imem_addr;
    logic [31:0] instr;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_we;
    logic [31:0] dmem_rdata;

    // Instruction ROM, data RAM and its random start contents.
    logic [31:0] rom [256];
    logic [31:0] ram [1024];
    logic [31:0] init_word [1024];
    int          wp = 0;

    // Expected stores in program order, tagged with their test.
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    int          exp_test [$];
    // Scoreboard of every store seen.
    logic [31:0] seen_addr [$];
    logic [31:0] seen_data [$];

    int exp_cnt [6];
    int done_cnt [6];
    int test_errs [6];
    int errors = 0;
    string names [6] = '{"reset_fetch", "alu_ops", "load_store_x0",
                         "branches", "jumps", "upper_imm"};

    `include "tb_program.svh"

    cpu_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .instr      (instr),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata)
    );

    always #10 clk = ~clk;

    // Both memories answer in the same cycle.
    assign instr = rom[imem_addr[9:2]];
    assign dmem_rdata = ram[dmem_addr[11:2]];

    // RAM reloads its start contents while in reset.
    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 1024; i++) begin
                ram[i] <= init_word[i];
            end
        end else if (dmem_we) begin
            ram[dmem_addr[11:2]] <= dmem_wdata;
        end
    end

    // Stores are checked mid cycle, where all outputs are settled.
    always @(negedge clk) begin : store_check
        int t;
        if (!rst_n) begin
            assert (dmem_we == 1'b0) else begin
                $display("Store enable was high during reset at %0t", $time);
                errors++;
                test_errs[0]++;
            end
        end else if (dmem_we) begin
            seen_addr.push_back(dmem_addr);
            seen_data.push_back(dmem_wdata);
            if (exp_addr.size() == 0) begin
                $display("Unexpected store to %h at %0t", dmem_addr, $time);
                errors++;
            end else begin
                t = exp_test[0];
                assert (dmem_addr == exp_addr[0]) else begin
                    $display("[FAIL] %0t dmem_addr: got %h expected %h",
                             $time, dmem_addr, exp_addr[0]);
                    errors++;
                    test_errs[t]++;
                end
                assert (dmem_wdata == exp_data[0]) else begin
                    $display("[FAIL] %0t dmem_wdata: got %h expected %h",
                             $time, dmem_wdata, exp_data[0]);
                    errors++;
                    test_errs[t]++;
                end
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
                void'(exp_test.pop_front());
                done_cnt[t]++;
            end
        end
    end

    initial begin : main
        int k;
        int t;
        int cycles;
        int pc_errs;
        int failed;
        rst_n = 1'b0;
        pc_errs = 0;
        failed = 0;
        void'($urandom(32'ha46c55e8));
        for (k = 0; k < 1024; k++) begin
            init_word[k] = $urandom();
        end
        // The two operands must differ for the branch pairs.
        if (init_word[1] == init_word[0]) begin
            init_word[1] = init_word[0] ^ 32'h1;
        end
        // Unused ROM holds ADDI x0 no-ops carrying their own index.
        for (k = 0; k < 256; k++) begin
            rom[k] = i_type(k[11:0], 5'd0, 3'b000, 5'd0, riscv_isa_pkg::op_imm);
        end
        build_program(init_word[0], init_word[1]);

        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;

        // First four instructions are straight-line code.
        for (k = 0; k < 4; k++) begin
            @(negedge clk);
            assert (imem_addr == 32'(k * 4)) else begin
                $display("[FAIL] %0t imem_addr: got %h expected %h",
                         $time, imem_addr, 32'(k * 4));
                pc_errs++;
            end
        end

        for (t = 0; t < 6; t++) begin
            cycles = 0;
            while (done_cnt[t] < exp_cnt[t] && cycles < 300) begin
                @(posedge clk);
                cycles++;
            end
            if (done_cnt[t] < exp_cnt[t]) begin
                $display("Test %s timed out waiting for its stores", names[t]);
                failed++;
            end else if (test_errs[t] != 0 || (t == 0 && pc_errs != 0)) begin
                $display("Test %s: FAILED with %0d errors", names[t],
                         test_errs[t] + ((t == 0) ? pc_errs : 0));
                failed++;
            end else begin
                $display("Test %s: ok, %0d stores", names[t], done_cnt[t]);
            end
        end

        // Let the last store reach the RAM before comparing its contents.
        @(negedge clk);
        check_ram_image();

        $display("Summary: %0d tests passed, %0d failed, %0d stores seen, %0d errors",
                 6 - failed, failed, seen_addr.size(), errors + pc_errs);
        if (failed == 0 && errors == 0 && pc_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Each stored address must hold the last value the scoreboard saw for it.
    task automatic check_ram_image();
        logic last;
        for (int i = 0; i < seen_addr.size(); i++) begin
            last = 1'b1;
            for (int j = i + 1; j < seen_addr.size(); j++) begin
                if (seen_addr[j] == seen_addr[i]) begin
                    last = 1'b0;
                end
            end
            if (last) begin
                assert (ram[seen_addr[i][11:2]] == seen_data[i]) else begin
                    $display("[FAIL] %0t ram[%h]: got %h expected %h",
                             $time, seen_addr[i], ram[seen_addr[i][11:2]], seen_data[i]);
                    errors++;
                end
            end
        end
    endtask

    // Test program, operands a and b are RAM words 0 and 1.
    task automatic build_program(input logic [31:0] a, input logic [31:0] b);
        logic [31:0] rnd;
        logic [11:0] imm;
        logic [31:0] simm;
        logic [31:0] here;
        logic [2:0]  f3;
        logic [4:0]  r1;
        logic [4:0]  r2;
        logic        taken;
        rnd = $urandom();
        imm = rnd[11:0];
        simm = {{20{imm[11]}}, imm};

        // A store sits at the reset vector, so it is fetched all through reset.
        store(0, 5'd0, 12'h0fc, 32'h0);
        // Operands into x1 and x2.
        emit(i_type(12'd0, 5'd0, riscv_isa_pkg::f3_word, 5'd1, riscv_isa_pkg::op_load));
        emit(i_type(12'd4, 5'd0, riscv_isa_pkg::f3_word, 5'd2, riscv_isa_pkg::op_load));
        store(0, 5'd1, 12'h100, a);

        alu_case(r_type(7'd0, 5'd2, 5'd1, 3'b000, 5'd4), 12'h104, a + b);
        alu_case(r_type(riscv_isa_pkg::funct7_alt, 5'd2, 5'd1, 3'b000, 5'd4), 12'h108, a - b);
        alu_case(r_type(7'd0, 5'd2, 5'd1, 3'b111, 5'd4), 12'h10c, a & b);
        alu_case(r_type(7'd0, 5'd2, 5'd1, 3'b110, 5'd4), 12'h110, a | b);
        alu_case(r_type(7'd0, 5'd2, 5'd1, 3'b100, 5'd4), 12'h114, a ^ b);
        alu_case(r_type(7'd0, 5'd2, 5'd1, 3'b010, 5'd4), 12'h118,
                 {31'b0, $signed(a) < $signed(b)});
        // Shifts use the low five bits of rs2.
        alu_case(r_type(7'd0, 5'd2, 5'd1, 3'b001, 5'd4), 12'h11c, a << b[4:0]);
        alu_case(r_type(7'd0, 5'd2, 5'd1, 3'b101, 5'd4), 12'h120, a >> b[4:0]);
        alu_case(r_type(riscv_isa_pkg::funct7_alt, 5'd2, 5'd1, 3'b101, 5'd4), 12'h124,
                 32'($signed(a) >>> b[4:0]));
        alu_case(i_type(imm, 5'd1, 3'b000, 5'd4, riscv_isa_pkg::op_imm), 12'h128, a + simm);
        alu_case(i_type(imm, 5'd1, 3'b111, 5'd4, riscv_isa_pkg::op_imm), 12'h12c, a & simm);
        alu_case(i_type(imm, 5'd1, 3'b110, 5'd4, riscv_isa_pkg::op_imm), 12'h130, a | simm);
        alu_case(i_type(imm, 5'd1, 3'b100, 5'd4, riscv_isa_pkg::op_imm), 12'h134, a ^ simm);
        alu_case(i_type(imm, 5'd1, 3'b010, 5'd4, riscv_isa_pkg::op_imm), 12'h138,
                 {31'b0, $signed(a) < $signed(simm)});

        // Store, reload, store again. Then a write aimed at x0.
        store(2, 5'd1, 12'h200, a);
        emit(i_type(12'h200, 5'd0, riscv_isa_pkg::f3_word, 5'd5, riscv_isa_pkg::op_load));
        store(2, 5'd5, 12'h204, a);
        emit(i_type(12'h5a5, 5'd0, 3'b000, 5'd0, riscv_isa_pkg::op_imm));
        store(2, 5'd0, 12'h208, 32'h0);

        // Markers, x6 for fall through and x7 for taken.
        emit(i_type(12'd1, 5'd0, 3'b000, 5'd6, riscv_isa_pkg::op_imm));
        emit(i_type(12'd2, 5'd0, 3'b000, 5'd7, riscv_isa_pkg::op_imm));
        for (int k = 0; k < 8; k++) begin
            f3 = (k < 2) ? 3'b000 : (k < 4) ? 3'b001 : (k < 6) ? 3'b100 : 3'b101;
            r1 = (k == 5 || k == 7) ? 5'd2 : 5'd1;
            r2 = (k == 0 || k == 2 || k == 5 || k == 7) ? 5'd1 : 5'd2;
            taken = branch_rule(f3, (r1 == 5'd1) ? a : b, (r2 == 5'd1) ? a : b);
            // Branch over the fall-through store and its skip jump.
            emit(b_type(13'd12, r2, r1, f3));
            emit(s_type(12'(12'h300 + 4 * k), 5'd6, 5'd0));
            emit(j_type(21'd8, 5'd0));
            emit(s_type(12'(12'h300 + 4 * k), 5'd7, 5'd0));
            expect_store(3, 12'(12'h300 + 4 * k), taken ? 32'd2 : 32'd1);
        end

        // JAL skips one store and links pc + 4.
        here = 32'(wp * 4);
        emit(j_type(21'd8, 5'd8));
        emit(s_type(12'h3f0, 5'd6, 5'd0));
        store(4, 5'd8, 12'h400, here + 32'd4);
        // JALR to x9 + 13 lands on x9 + 12.
        here = 32'(wp * 4);
        emit(u_type(20'd0, 5'd9, riscv_isa_pkg::op_auipc));
        emit(i_type(12'd13, 5'd9, 3'b000, 5'd10, riscv_isa_pkg::op_jalr));
        emit(s_type(12'h3f4, 5'd6, 5'd0));
        store(4, 5'd10, 12'h404, here + 32'd8);
        store(4, 5'd9, 12'h408, here);

        rnd = $urandom();
        emit(u_type(rnd[31:12], 5'd11, riscv_isa_pkg::op_lui));
        store(5, 5'd11, 12'h40c, {rnd[31:12], 12'h0});
        here = 32'(wp * 4);
        emit(u_type(rnd[19:0], 5'd12, riscv_isa_pkg::op_auipc));
        store(5, 5'd12, 12'h410, {rnd[19:0], 12'h0} + here);

        // Park on a jump to itself.
        emit(j_type(21'd0, 5'd0));
    endtask
endmodule

`default_nettype wire
